// File: include/processor_cfg.svh
// widths and fixed register indices of the 16-bit pipeline
// the instruction layout assumes
// OPCODE_BITS + 1 + REG_BITS + IMM_BITS == WORD_SIZE
// register PC_REG doubles as the program counter
`ifndef PROCESSOR_CFG_SVH
`define PROCESSOR_CFG_SVH

// data and instruction word
`define WORD_SIZE 16

// register file
`define NUM_REGS 8
`define REG_BITS 3

// instruction fields
`define OPCODE_BITS 3
`define IMM_BITS 9

// program counter lives in the register file
`define PC_REG 7

`endif

// File: verilog/processor_pkg.sv
// shared types of the six-stage pipeline
// an all-zero stage record is a no-op, so every enum keeps its "none" value at zero
// instruction layout: opcode | imm | rx | 9-bit immediate, or 6 zero bits and ry
`include "processor_cfg.svh"

package processor_pkg;

    typedef enum logic [`OPCODE_BITS-1:0] {
        op_mv    = 3'b000,
        op_mvt_b = 3'b001,  // move-top when imm set, branch otherwise
        op_add   = 3'b010,
        op_sub   = 3'b011,
        op_ld    = 3'b100,
        op_st    = 3'b101,
        op_and   = 3'b110,  // not implemented, decodes to a no-op
        op_other = 3'b111   // compare lives here
    } opcode_e;

    typedef enum logic [1:0] {
        alu_none = 2'd0,
        alu_mov  = 2'd1,
        alu_add  = 2'd2,
        alu_sub  = 2'd3
    } alu_op_e;

    // encoded in the rx field of a branch
    typedef enum logic [2:0] {
        cond_none = 3'd0,
        cond_eq   = 3'd1,
        cond_ne   = 3'd2,
        cond_cc   = 3'd3,
        cond_cs   = 3'd4,
        cond_pl   = 3'd5,
        cond_mi   = 3'd6
    } cond_e;

    typedef struct packed {
        logic negative;
        logic zero;
        logic carry;
        logic overflow;
    } flags_t;

    typedef union packed {
        struct packed {
            opcode_e               opcode;
            logic                  imm;
            logic [`REG_BITS-1:0]  rx;
            logic [5:0]            zero_bits;  // must be zero for register-form compare
            logic [`REG_BITS-1:0]  ry;
        } reg_form;
        struct packed {
            opcode_e               opcode;
            logic                  imm;
            logic [`REG_BITS-1:0]  rx;
            logic [`IMM_BITS-1:0]  value;      // sign-extended on use
        } imm_form;
    } instr_u;

    typedef struct packed {
        logic [`WORD_SIZE-1:0] op1;           // rx value, store data
        logic [`WORD_SIZE-1:0] op2;           // ry value or immediate, memory address
        logic [`WORD_SIZE-1:0] out;           // result, load data
        logic [`REG_BITS-1:0]  rx;
        logic [`REG_BITS-1:0]  ry;
        logic                  uses_ry;
        logic                  writeback;     // result goes to rx
        logic                  read;
        logic                  write;
        logic                  is_branch;
        logic                  update_flags;
        alu_op_e               alu_op;
        cond_e                 cond;
        logic [`WORD_SIZE-1:0] pc_next;       // address after this instruction
    } stage_rec_t;

endpackage

// File: verilog/register_file.sv
// eight 16-bit registers, register PC_REG is the program counter
// reads and pc see a write of the same cycle (write-through), so a record in
// writeback needs no stall; when fetch and a PC write meet, the increment
// starts from the written value
`include "processor_cfg.svh"

module register_file (
    input  logic                  Clock,
    input  logic                  Reset,
    input  logic [`REG_BITS-1:0]  rd_addr_a,
    input  logic [`REG_BITS-1:0]  rd_addr_b,
    output logic [`WORD_SIZE-1:0] rd_data_a,
    output logic [`WORD_SIZE-1:0] rd_data_b,
    input  logic                  wr_en,
    input  logic [`REG_BITS-1:0]  wr_addr,
    input  logic [`WORD_SIZE-1:0] wr_data,
    input  logic                  pc_advance,
    output logic [`WORD_SIZE-1:0] pc
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

    // write-through read ports
    assign rd_data_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

    // a branch target shows up as the fetch address right away
    assign pc = (wr_en && wr_addr == `REG_BITS'(`PC_REG)) ? wr_data : regs[`PC_REG];

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_en) begin
                regs[wr_addr] <= wr_data;
            end
            if (pc_advance) begin
                regs[`PC_REG] <= pc + 1'b1;  // pc already holds any PC write
            end
        end
    end

endmodule

// File: verilog/instr_decoder.sv
// decodes the fetched word into a stage record, purely combinational
// an all-zero word is treated as a no-op (fetch bubbles are zero words)
// and, the link branch condition and malformed compares also decode to a no-op
// load and store always take the address from ry, whatever the imm bit says
`include "processor_cfg.svh"

module instr_decoder (
    input  processor_pkg::instr_u     word,
    input  logic [`WORD_SIZE-1:0]     pc_next,
    input  logic [`WORD_SIZE-1:0]     rd_data_a,
    input  logic [`WORD_SIZE-1:0]     rd_data_b,
    output processor_pkg::stage_rec_t rec
);

    logic                  is_imm;
    logic [`WORD_SIZE-1:0] imm_ext;

    assign is_imm  = word.imm_form.imm;
    assign imm_ext = {{(`WORD_SIZE-`IMM_BITS){word.imm_form.value[`IMM_BITS-1]}},
                      word.imm_form.value};

    always_comb begin
        rec = '0;
        if (word != '0) begin
            // common fields, refined per opcode below
            rec.rx      = word.reg_form.rx;
            rec.ry      = word.reg_form.ry;
            rec.op1     = rd_data_a;
            rec.op2     = is_imm ? imm_ext : rd_data_b;
            rec.uses_ry = !is_imm;
            rec.pc_next = pc_next;

            case (word.reg_form.opcode)
                processor_pkg::op_mv: begin
                    rec.alu_op    = processor_pkg::alu_mov;
                    rec.writeback = 1'b1;
                end
                processor_pkg::op_mvt_b: begin
                    if (is_imm) begin
                        // move-top, low byte of the result is cleared
                        rec.alu_op    = processor_pkg::alu_mov;
                        rec.op2       = {word.imm_form.value[7:0], {(`WORD_SIZE-8){1'b0}}};
                        rec.writeback = 1'b1;
                    end else if (word.reg_form.rx != 3'd7) begin
                        rec.op2       = imm_ext;  // offset from pc_next
                        rec.uses_ry   = 1'b0;
                        rec.is_branch = 1'b1;
                        rec.cond      = processor_pkg::cond_e'(word.reg_form.rx);
                    end else begin
                        rec = '0;                 // link condition
                    end
                end
                processor_pkg::op_add: begin
                    rec.alu_op    = processor_pkg::alu_add;
                    rec.writeback = 1'b1;
                end
                processor_pkg::op_sub: begin
                    rec.alu_op    = processor_pkg::alu_sub;
                    rec.writeback = 1'b1;
                end
                processor_pkg::op_ld: begin
                    rec.op2       = rd_data_b;
                    rec.uses_ry   = 1'b1;
                    rec.read      = 1'b1;
                    rec.writeback = 1'b1;
                end
                processor_pkg::op_st: begin
                    rec.op2     = rd_data_b;
                    rec.uses_ry = 1'b1;
                    rec.write   = 1'b1;
                end
                processor_pkg::op_other: begin
                    if (is_imm || word.reg_form.zero_bits == '0) begin
                        rec.alu_op       = processor_pkg::alu_sub;  // compare
                        rec.update_flags = 1'b1;
                    end else begin
                        rec = '0;
                    end
                end
                default: rec = '0;
            endcase
        end
    end

endmodule

// File: verilog/hazard_unit.sv
// RAW and control hazard detection, no forwarding
// inflight holds the records in decode, execute, memory 1 and memory 2;
// writeback is covered by the write-through register file
// a branch anywhere from fetch to memory 2 holds fetch
`include "processor_cfg.svh"

module hazard_unit (
    input  processor_pkg::stage_rec_t dec_rec,
    input  logic                      fetch_is_branch,
    input  processor_pkg::stage_rec_t inflight [4],
    output logic                      decode_stall,
    output logic                      fetch_stall
);

    logic check_rx;
    logic branch_seen;

    // rx is a source or a destination for everything except branches and no-ops
    assign check_rx = dec_rec.writeback | dec_rec.read | dec_rec.write
                    | dec_rec.update_flags;

    always_comb begin
        decode_stall = 1'b0;
        branch_seen  = fetch_is_branch;
        for (int i = 0; i < 4; i++) begin
            if (inflight[i].writeback) begin
                if (check_rx && inflight[i].rx == dec_rec.rx) begin
                    decode_stall = 1'b1;
                end
                if (dec_rec.uses_ry && inflight[i].rx == dec_rec.ry) begin
                    decode_stall = 1'b1;
                end
            end
            if (inflight[i].is_branch) begin
                branch_seen = 1'b1;
            end
        end
    end

    assign fetch_stall = decode_stall | branch_seen;

endmodule

// File: verilog/execute_unit.sv
// ALU, branch condition and the NZCV flag register
// only compare loads the flags; overflow is computed for subtract only
// carry after subtract is the borrow out of bit 15
// a branch with a false condition leaves as a no-op record
`include "processor_cfg.svh"

module execute_unit (
    input  logic                      Clock,
    input  logic                      Reset,
    input  logic                      advance,
    input  processor_pkg::stage_rec_t in_rec,
    output processor_pkg::stage_rec_t out_rec
);

    localparam int MSB = `WORD_SIZE - 1;

    processor_pkg::flags_t flags;
    processor_pkg::flags_t flags_next;
    logic [`WORD_SIZE-1:0] result;
    logic                  carry;
    logic                  cond_met;

    always_comb begin
        carry  = 1'b0;
        result = in_rec.out;
        case (in_rec.alu_op)
            processor_pkg::alu_mov: result = in_rec.op2;
            processor_pkg::alu_add: {carry, result} = {1'b0, in_rec.op1} + {1'b0, in_rec.op2};
            processor_pkg::alu_sub: {carry, result} = {1'b0, in_rec.op1} - {1'b0, in_rec.op2};
            default: ;
        endcase
    end

    always_comb begin
        flags_next.negative = result[MSB];
        flags_next.zero     = (result == '0);
        flags_next.carry    = carry;
        flags_next.overflow = (in_rec.alu_op == processor_pkg::alu_sub)
                            && (in_rec.op1[MSB] != in_rec.op2[MSB])
                            && (result[MSB] != in_rec.op1[MSB]);
    end

    always_comb begin
        case (in_rec.cond)
            processor_pkg::cond_eq: cond_met = flags.zero;
            processor_pkg::cond_ne: cond_met = !flags.zero;
            processor_pkg::cond_cc: cond_met = !flags.carry;
            processor_pkg::cond_cs: cond_met = flags.carry;
            processor_pkg::cond_pl: cond_met = !flags.zero && !flags.negative;  // strictly positive
            processor_pkg::cond_mi: cond_met = !flags.zero && flags.negative;
            default:                cond_met = 1'b1;
        endcase
    end

    always_comb begin
        out_rec     = in_rec;
        out_rec.out = result;
        if (in_rec.is_branch) begin
            if (cond_met) begin
                out_rec.out       = in_rec.pc_next + in_rec.op2;
                out_rec.rx        = `REG_BITS'(`PC_REG);
                out_rec.writeback = 1'b1;  // target goes to the PC in writeback
            end else begin
                out_rec = '0;
            end
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            flags <= '0;
        end else if (advance && in_rec.update_flags) begin
            flags <= flags_next;
        end
    end

endmodule

// File: verilog/memory_stage.sv
// data port of the pipeline, driven straight from the memory 1 record
// a request stays up until DataDone is seen high at a rising edge;
// load data must be valid on DataIn in that same cycle
// if Enable is low while DataDone is high, the access is repeated later
`include "processor_cfg.svh"

module memory_stage (
    input  processor_pkg::stage_rec_t m1_rec,
    input  logic [`WORD_SIZE-1:0]     DataIn,
    input  logic                      DataDone,
    output logic [`WORD_SIZE-1:0]     DataAddr,
    output logic [`WORD_SIZE-1:0]     DataOut,
    output logic                      ReadData,
    output logic                      WriteData,
    output logic                      mem_wait,
    output processor_pkg::stage_rec_t m2_rec
);

    logic request;

    assign request = m1_rec.read | m1_rec.write;

    // address and data stay stable as long as memory 1 holds
    assign DataAddr  = m1_rec.op2;
    assign DataOut   = m1_rec.op1;
    assign ReadData  = m1_rec.read;
    assign WriteData = m1_rec.write;

    assign mem_wait = request & ~DataDone;  // holds the whole pipeline

    always_comb begin
        m2_rec = m1_rec;
        if (m1_rec.read) begin
            m2_rec.out = DataIn;  // load result
        end
    end

endmodule

// File: verilog/processor.sv
// six-stage in-order 16-bit processor: fetch, decode, execute, memory 1,
// memory 2, writeback
// instruction memory must answer InstrIn in the same cycle as InstrAddr
// writes to r7 other than by a branch are not guarded, wrong-path fetches follow
// everything holds while Enable is low or a data access waits for DataDone
`include "processor_cfg.svh"

module processor (
    input  logic                  Clock,
    input  logic                  Reset,
    input  logic                  Enable,
    input  logic [`WORD_SIZE-1:0] InstrIn,
    input  logic [`WORD_SIZE-1:0] DataIn,
    input  logic                  DataDone,
    output logic [`WORD_SIZE-1:0] InstrAddr,
    output logic [`WORD_SIZE-1:0] DataAddr,
    output logic [`WORD_SIZE-1:0] DataOut,
    output logic                  ReadData,
    output logic                  WriteData
);

    processor_pkg::instr_u     fetch_word;
    logic [`WORD_SIZE-1:0]     fetch_pc_next;
    processor_pkg::stage_rec_t dec_r, ex_r, m1_r, m2_r, wb_r;  // record in each stage
    processor_pkg::stage_rec_t dec_next, ex_next, m2_next;
    processor_pkg::stage_rec_t inflight [4];

    logic [`WORD_SIZE-1:0] rd_data_a, rd_data_b;
    logic [`WORD_SIZE-1:0] pc;
    logic                  advance, mem_wait;
    logic                  decode_stall, fetch_stall;
    logic                  fetch_is_branch;

    assign advance   = Enable & ~mem_wait;
    assign InstrAddr = pc;

    assign fetch_is_branch = (fetch_word.imm_form.opcode == processor_pkg::op_mvt_b)
                           && !fetch_word.imm_form.imm;

    assign inflight[0] = dec_r;
    assign inflight[1] = ex_r;
    assign inflight[2] = m1_r;
    assign inflight[3] = m2_r;

    register_file u_regs (
        .Clock      (Clock),
        .Reset      (Reset),
        .rd_addr_a  (fetch_word.reg_form.rx),
        .rd_addr_b  (fetch_word.reg_form.ry),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .wr_en      (advance & wb_r.writeback),  // one write per record
        .wr_addr    (wb_r.rx),
        .wr_data    (wb_r.out),
        .pc_advance (advance & ~fetch_stall),
        .pc         (pc)
    );

    instr_decoder u_dec (
        .word      (fetch_word),
        .pc_next   (fetch_pc_next),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .rec       (dec_next)
    );

    hazard_unit u_hazard (
        .dec_rec         (dec_next),
        .fetch_is_branch (fetch_is_branch),
        .inflight        (inflight),
        .decode_stall    (decode_stall),
        .fetch_stall     (fetch_stall)
    );

    execute_unit u_exec (
        .Clock   (Clock),
        .Reset   (Reset),
        .advance (advance),
        .in_rec  (dec_r),
        .out_rec (ex_next)
    );

    memory_stage u_mem (
        .m1_rec    (m1_r),
        .DataIn    (DataIn),
        .DataDone  (DataDone),
        .DataAddr  (DataAddr),
        .DataOut   (DataOut),
        .ReadData  (ReadData),
        .WriteData (WriteData),
        .mem_wait  (mem_wait),
        .m2_rec    (m2_next)
    );

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            fetch_word    <= '0;
            fetch_pc_next <= '0;
            dec_r         <= '0;
            ex_r          <= '0;
            m1_r          <= '0;
            m2_r          <= '0;
            wb_r          <= '0;
        end else if (advance) begin
            if (decode_stall) begin
                dec_r <= '0;                   // bubble into execute, fetch holds
            end else begin
                dec_r <= dec_next;
                if (fetch_stall) begin
                    fetch_word <= '0;          // branch in flight
                end else begin
                    fetch_word    <= InstrIn;
                    fetch_pc_next <= pc + 1'b1;
                end
            end
            ex_r <= ex_next;
            m1_r <= ex_r;
            m2_r <= m2_next;
            wb_r <= m2_r;
        end
    end

endmodule

// File: verif/mem_model.sv
// instruction and data memory for the processor testbench
// both arrays hold 256 words and decode only the low address byte
// instruction and data reads are combinational
// DataDone follows a request after 0 to 3 extra wait cycles from an xorshift
// a store to 16'hffff is logged and sets halted, memory is not written
// reset clears the store log and refills the data array
`include "processor_cfg.svh"

module mem_model (
    input  logic                  Clock,
    input  logic                  Reset,
    input  logic [`WORD_SIZE-1:0] InstrAddr,
    output logic [`WORD_SIZE-1:0] InstrIn,
    input  logic [`WORD_SIZE-1:0] DataAddr,
    input  logic [`WORD_SIZE-1:0] DataOut,
    input  logic                  ReadData,
    input  logic                  WriteData,
    output logic [`WORD_SIZE-1:0] DataIn,
    output logic                  DataDone
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [15:0] HALT_ADDR = 16'hffff;
    localparam int          LOG_DEPTH = 64;

    logic [15:0] imem [256];      // filled by the testbench
    logic [15:0] dmem [256];
    logic [15:0] log_addr [LOG_DEPTH];
    logic [15:0] log_data [LOG_DEPTH];
    int          log_count;
    logic        halted;
    logic [31:0] rng = 32'ha031;
    logic [31:0] rng_next;
    logic [1:0]  wait_cnt;        // wait cycles left for the current request

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    assign InstrIn  = imem[InstrAddr[7:0]];
    assign DataIn   = dmem[DataAddr[7:0]];
    assign rng_next = xorshift32(rng);

    always @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            DataDone  <= 1'b0;
            halted    <= 1'b0;
            log_count <= 0;
            wait_cnt  <= rng[1:0];
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= {i[7:0] ^ 8'h5a, ~i[7:0]};
            end
        end else if (DataDone) begin
            // access completes at this edge
            DataDone <= 1'b0;
            rng      <= rng_next;
            wait_cnt <= rng_next[1:0];  // delay of the next request
            if (WriteData) begin
                if (log_count < LOG_DEPTH) begin
                    log_addr[log_count] <= DataAddr;
                    log_data[log_count] <= DataOut;
                end
                log_count <= log_count + 1;
                if (DataAddr == HALT_ADDR) begin
                    halted <= 1'b1;
                end else begin
                    dmem[DataAddr[7:0]] <= DataOut;
                end
            end
        end else if (ReadData || WriteData) begin
            if (wait_cnt == 2'd0) begin
                DataDone <= 1'b1;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

// File: verif/processor_tb.sv
// directed tests of the six-stage processor
// each program ends with a store to 16'hffff, which stops the run of that test
// register r6 is the store address scratch register in every program
// the first mismatch ends the simulation
`include "processor_cfg.svh"

module processor_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLOCK_PERIOD    = 40;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 2000;
    localparam int MAX_STORES      = 64;

    logic                  Clock;
    logic                  Reset;
    logic                  Enable;
    logic [`WORD_SIZE-1:0] InstrIn;
    logic [`WORD_SIZE-1:0] DataIn;
    logic                  DataDone;
    logic [`WORD_SIZE-1:0] InstrAddr;
    logic [`WORD_SIZE-1:0] DataAddr;
    logic [`WORD_SIZE-1:0] DataOut;
    logic                  ReadData;
    logic                  WriteData;

    string       test_name;
    int          prog_len;
    int          gap;          // no-ops placed after each emitted word
    int          exp_count;
    logic [15:0] exp_addr [MAX_STORES];
    logic [15:0] exp_data [MAX_STORES];

    processor UUT (
        .Clock     (Clock),
        .Reset     (Reset),
        .Enable    (Enable),
        .InstrIn   (InstrIn),
        .DataIn    (DataIn),
        .DataDone  (DataDone),
        .InstrAddr (InstrAddr),
        .DataAddr  (DataAddr),
        .DataOut   (DataOut),
        .ReadData  (ReadData),
        .WriteData (WriteData)
    );

    mem_model memory (
        .Clock     (Clock),
        .Reset     (Reset),
        .InstrAddr (InstrAddr),
        .InstrIn   (InstrIn),
        .DataAddr  (DataAddr),
        .DataOut   (DataOut),
        .ReadData  (ReadData),
        .WriteData (WriteData),
        .DataIn    (DataIn),
        .DataDone  (DataDone)
    );

    always #(CLOCK_PERIOD / 2) Clock = ~Clock;

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLOCK_PERIOD);
        $display("watchdog expired: tests did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation timed out");
    end

    task automatic check_value(input string label, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED: test %s, %s: expected %0h, actual %0h",
                     test_name, label, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // opcode | imm | rx | low nine bits
    function automatic logic [15:0] encode(input logic [2:0] op, input logic imm,
                                           input logic [2:0] rx, input logic [8:0] low);
        return {op, imm, rx, low};
    endfunction

    function automatic logic branch_taken(input logic [2:0] cond, input logic [15:0] a,
                                          input logic [15:0] b);
        logic [15:0] diff;
        logic        n;
        logic        z;
        logic        c;
        diff = a - b;
        n    = diff[15];
        z    = (diff == 16'h0000);
        c    = (a < b);  // borrow
        case (cond)
            3'd1:    return z;
            3'd2:    return !z;
            3'd3:    return !c;
            3'd4:    return c;
            3'd5:    return !n && !z;
            3'd6:    return n;
            default: return 1'b1;
        endcase
    endfunction

    task automatic emit(input logic [15:0] word);
        memory.imem[prog_len] = word;
        prog_len = prog_len + 1 + gap;  // gap words are already zero
    endtask

    task automatic emit_imm(input logic [2:0] op, input logic [2:0] rx, input int value);
        emit(encode(op, 1'b1, rx, value[8:0]));
    endtask

    task automatic emit_reg(input logic [2:0] op, input logic [2:0] rx, input logic [2:0] ry);
        emit(encode(op, 1'b0, rx, {6'b000000, ry}));
    endtask

    task automatic expect_store(input logic [7:0] addr, input logic [15:0] value);
        exp_addr[exp_count] = {8'h00, addr};
        exp_data[exp_count] = value;
        exp_count++;
    endtask

    task automatic store_and_expect(input logic [2:0] rx, input logic [7:0] addr,
                                    input logic [15:0] value);
        emit_imm(processor_pkg::op_mv, 3'd6, addr);
        emit_reg(processor_pkg::op_st, rx, 3'd6);
        expect_store(addr, value);
    endtask

    task automatic emit_halt();
        emit_imm(processor_pkg::op_mv, 3'd6, -1);
        emit_reg(processor_pkg::op_st, 3'd6, 3'd6);
    endtask

    // program is written while reset is held
    task automatic begin_program(input string name);
        test_name = name;
        for (int i = 0; i < 256; i++) begin
            memory.imem[i] = '0;
        end
        prog_len  = 0;
        gap       = 0;
        exp_count = 0;
        @(posedge Clock);
        Reset  <= 1'b1;
        Enable <= 1'b1;
    endtask

    task automatic release_reset();
        repeat (10) @(posedge Clock);
        Reset <= 1'b0;
    endtask

    task automatic run_program();
        release_reset();
        while (!memory.halted) @(posedge Clock);
        @(negedge Clock);
        check_value("store count", exp_count + 1, memory.log_count);
        for (int i = 0; i < exp_count; i++) begin
            check_value("store address", exp_addr[i], memory.log_addr[i]);
            check_value("store data", exp_data[i], memory.log_data[i]);
        end
    endtask

    task automatic test_reset();
        begin_program("reset");
        release_reset();
        @(negedge Clock);
        check_value("ReadData", 0, ReadData);
        check_value("WriteData", 0, WriteData);
        check_value("InstrAddr", 0, InstrAddr);
    endtask

    task automatic test_arith();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        begin_program("arithmetic");
        a = 16'd37;
        b = 16'hfffb;  // -5
        emit_imm(processor_pkg::op_mv, 3'd1, 37);
        store_and_expect(3'd1, 8'h10, a);
        emit_imm(processor_pkg::op_mv, 3'd2, -5);
        emit_reg(processor_pkg::op_mv, 3'd3, 3'd2);
        c = b;
        store_and_expect(3'd3, 8'h11, c);
        emit_imm(processor_pkg::op_add, 3'd3, 200);
        c = c + 16'd200;
        store_and_expect(3'd3, 8'h12, c);
        emit_reg(processor_pkg::op_add, 3'd3, 3'd1);
        c = c + a;
        store_and_expect(3'd3, 8'h13, c);
        emit_imm(processor_pkg::op_sub, 3'd3, 250);
        c = c - 16'd250;
        store_and_expect(3'd3, 8'h14, c);
        emit_reg(processor_pkg::op_sub, 3'd3, 3'd2);
        c = c - b;
        store_and_expect(3'd3, 8'h15, c);
        emit_reg(processor_pkg::op_sub, 3'd1, 3'd2);
        a = a - b;
        store_and_expect(3'd1, 8'h16, a);
        emit_halt();
        run_program();
    endtask

    task automatic test_movetop();
        logic [7:0]  hi;
        logic [7:0]  lo;
        logic [15:0] value;
        begin_program("move-top round trip");
        for (int k = 0; k < 4; k++) begin
            hi    = 8'h5a ^ 8'(k * 55);
            lo    = 8'(8'hc3 + k * 41);
            value = {hi, 8'h00} + {8'h00, lo};  // upper byte from move-top, then add
            emit(encode(processor_pkg::op_mvt_b, 1'b1, 3'd1, {1'b0, hi}));
            emit_imm(processor_pkg::op_add, 3'd1, lo);
            store_and_expect(3'd1, 8'(8'h20 + 2 * k), value);
            emit_reg(processor_pkg::op_ld, 3'd2, 3'd6);
            emit_imm(processor_pkg::op_mv, 3'd5, 8'h21 + 2 * k);
            emit_reg(processor_pkg::op_st, 3'd2, 3'd5);
            expect_store(8'(8'h21 + 2 * k), value);
        end
        emit_halt();
        run_program();
    endtask

    // dependent chain, every instruction reads the result just before it
    task automatic emit_raw_chain(input int spacing);
        logic [15:0] r1;
        logic [15:0] r2;
        logic [15:0] r3;
        gap = spacing;
        r1  = 16'd3;
        emit_imm(processor_pkg::op_mv, 3'd1, 3);
        emit_reg(processor_pkg::op_add, 3'd1, 3'd1);
        r1 = r1 + r1;
        emit_imm(processor_pkg::op_add, 3'd1, -1);
        r1 = r1 + 16'hffff;
        emit_reg(processor_pkg::op_mv, 3'd2, 3'd1);
        r2 = r1;
        emit_imm(processor_pkg::op_sub, 3'd2, 9);
        r2 = r2 - 16'd9;
        emit_reg(processor_pkg::op_add, 3'd2, 3'd1);
        r2 = r2 + r1;
        emit_reg(processor_pkg::op_sub, 3'd1, 3'd2);
        r1 = r1 - r2;
        store_and_expect(3'd1, 8'h30, r1);
        store_and_expect(3'd2, 8'h31, r2);
        emit_reg(processor_pkg::op_ld, 3'd3, 3'd6);  // load-use on r3
        r3 = r2;
        emit_reg(processor_pkg::op_add, 3'd3, 3'd3);
        r3 = r3 + r3;
        store_and_expect(3'd3, 8'h32, r3);
    endtask

    // both runs are held to the same expected stores
    task automatic test_raw();
        begin_program("raw chain with no-ops");
        emit_raw_chain(4);
        emit_halt();
        run_program();
        begin_program("raw chain back to back");
        emit_raw_chain(0);
        emit_halt();
        run_program();
    endtask

    task automatic test_branches();
        int         a_val [15] = '{5, 5, 5, 5, 5, 6, 5, 6, 7, 3, 5, 3, 7, -3, 0};
        int         b_val [15] = '{5, 6, 6, 5, 6, 5, 6, 5, 3, 7, 5, 7, 3, 2, 0};
        logic [2:0] cond  [15] = '{1, 1, 2, 2, 3, 3, 4, 4, 5, 5, 5, 6, 6, 6, 0};
        begin_program("compare and branch");
        for (int i = 0; i < 15; i++) begin
            emit_imm(processor_pkg::op_mv, 3'd1, a_val[i]);
            emit_imm(processor_pkg::op_mv, 3'd2, b_val[i]);
            emit_imm(processor_pkg::op_mv, 3'd5, i + 1);  // marker value
            if (i % 2 == 1) begin
                emit_reg(processor_pkg::op_other, 3'd1, 3'd2);
            end else begin
                emit_imm(processor_pkg::op_other, 3'd1, b_val[i]);
            end
            emit(encode(processor_pkg::op_mvt_b, 1'b0, cond[i], 9'd2));  // skips the marker
            emit_imm(processor_pkg::op_mv, 3'd6, 8'h40 + i);
            emit_reg(processor_pkg::op_st, 3'd5, 3'd6);
            if (!branch_taken(cond[i], 16'(a_val[i]), 16'(b_val[i]))) begin
                expect_store(8'(8'h40 + i), 16'(i + 1));
            end
        end
        emit_halt();
        run_program();
    endtask

    initial begin
        Clock  = 1'b0;
        Reset  = 1'b1;
        Enable = 1'b0;
        test_reset();
        test_arith();
        test_movetop();
        test_raw();
        test_branches();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: processor.f
+incdir+include
verilog/processor_pkg.sv
verilog/register_file.sv
verilog/instr_decoder.sv
verilog/hazard_unit.sv
verilog/execute_unit.sv
verilog/memory_stage.sv
verilog/processor.sv
verif/mem_model.sv
verif/processor_tb.sv
